//--- compile.f
+incdir+source
+incdir+verif
source/cl_rst_pkg.sv
source/cl_ddr_stat_pkg.sv
source/lib_pipe.sv
source/cl_rst_ctrl.sv
source/cl_dram_dma.sv
verif/tb_cl_dram_dma.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_cl_dram_dma
FILELIST = compile.f
OBJ_DIR  = obj_dir
PASS_MSG = All checks passed

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tb_cl_dram_dma_tasks.svh
// Directed tests for reset release, status pipes, FLR and mid-run reset

   // ----------------------------------------------------------------------
   // Reset release
   // ----------------------------------------------------------------------

   // Entered on the edge that ends the initial reset
   task automatic test_reset_release();
      int unsigned err_before;
      err_before = err_cnt;
      rst_main_n <= 1'b1;
      for (int k = 1; k <= BLK_RST_RISE; k++)
      begin
         @(posedge clk);
         @(negedge clk);
         // Low until the last stage of the tree lets go
         check_val("block_rst_n", 32'(block_rst_n),
                   32'({NUM_RST_DOMAINS{k == BLK_RST_RISE}}));
         check_stat_zero();
      end
      report_test("reset_release", err_before);
   endtask

   // ----------------------------------------------------------------------
   // Request path
   // ----------------------------------------------------------------------

   task automatic test_request_path();
      ddr_stat_req_t beats [REQ_BEATS][`NUM_DDR_STAT];
      ddr_stat_req_t want;
      int unsigned   err_before;
      err_before = err_cnt;
      for (int i = 0; i < REQ_BEATS + LAT; i++)
      begin
         @(posedge clk);
         for (int ch = 0; ch < `NUM_DDR_STAT; ch++)
         begin
            if (i < REQ_BEATS)
            begin
               drive_rand_req(ch, beats[i][ch]);
            end
            else
            begin
               drive_idle(ch);
            end
         end
         @(negedge clk);
         for (int ch = 0; ch < `NUM_DDR_STAT; ch++)
         begin
            // Idle until the first beat has crossed all stages
            want = (i >= LAT) ? beats[i-LAT][ch] : '0;
            check_val($sformatf("sh_ddr_stat_wr_q[%0d]", ch), 32'(sh_ddr_stat_wr_q[ch]),
                      32'(want.wr));
            check_val($sformatf("sh_ddr_stat_rd_q[%0d]", ch), 32'(sh_ddr_stat_rd_q[ch]),
                      32'(want.rd));
            check_val($sformatf("sh_ddr_stat_addr_q[%0d]", ch), 32'(sh_ddr_stat_addr_q[ch]),
                      32'(want.addr));
            check_val($sformatf("sh_ddr_stat_wdata_q[%0d]", ch), sh_ddr_stat_wdata_q[ch],
                      want.wdata);
         end
      end
      report_test("request_path", err_before);
   endtask

   // ----------------------------------------------------------------------
   // Response path
   // ----------------------------------------------------------------------

   task automatic test_response_path();
      ddr_stat_req_t req;
      ddr_stat_rsp_t want;
      logic [31:0]   r;
      int            max_fly;
      int unsigned   err_before;
      err_before = err_cnt;
      max_fly    = 0;
      // Let responses to earlier traffic drain first
      repeat (LAT + 2) @(negedge clk);
      for (int ch = 0; ch < `NUM_DDR_STAT; ch++)
      begin
         exp_rsp[ch].delete();
         exp_due[ch].delete();
      end
      for (int i = 0; i < RSP_ISSUE + 2 * LAT + 3; i++)
      begin
         @(posedge clk);
         for (int ch = 0; ch < `NUM_DDR_STAT; ch++)
         begin
            // Roughly three busy cycles in four, uneven per channel
            r = $random(seed);
            if (i < RSP_ISSUE && r[1:0] != 2'b00)
            begin
               drive_rand_req(ch, req);
            end
            else
            begin
               drive_idle(ch);
            end
         end
         @(negedge clk);
         for (int ch = 0; ch < `NUM_DDR_STAT; ch++)
         begin
            if (exp_due[ch].size() > max_fly)
            begin
               max_fly = exp_due[ch].size();
            end
            if (exp_due[ch].size() > 0 && exp_due[ch][0] == cyc)
            begin
               want = exp_rsp[ch].pop_front();
               void'(exp_due[ch].pop_front());
               check_val($sformatf("ddr_sh_stat_ack[%0d]", ch), 32'(ddr_sh_stat_ack[ch]), 32'h1);
               check_val($sformatf("ddr_sh_stat_int[%0d]", ch), 32'(ddr_sh_stat_int[ch]),
                         32'(want.intr));
               check_val($sformatf("ddr_sh_stat_rdata[%0d]", ch), ddr_sh_stat_rdata[ch],
                         want.rdata);
            end
            else
            begin
               check_val($sformatf("ddr_sh_stat_ack[%0d]", ch), 32'(ddr_sh_stat_ack[ch]), 32'h0);
            end
         end
      end
      for (int ch = 0; ch < `NUM_DDR_STAT; ch++)
      begin
         check_cond(exp_due[ch].size() == 0,
                    $sformatf("channel %0d has responses that never reached the shell", ch));
      end
      check_cond(max_fly > 1, "return pipes never held more than one response");
      report_test("response_path", err_before);
   endtask

   // ----------------------------------------------------------------------
   // FLR
   // ----------------------------------------------------------------------

   task automatic test_flr();
      logic        want_done;
      int unsigned err_before;
      err_before = err_cnt;
      for (int k = 0; k <= FLR_HOLD + 4; k++)
      begin
         @(posedge clk);
         sh_cl_flr_assert <= (k < FLR_HOLD);
         @(negedge clk);
         // First pulse two cycles in, then every other cycle
         want_done = (k >= 2) && (k % 2 == 0);
         // One cycle of slack after release
         if (k <= FLR_HOLD)
         begin
            check_val("cl_sh_flr_done", 32'(cl_sh_flr_done), 32'(want_done));
         end
         else if (k >= FLR_HOLD + 2)
         begin
            check_val("cl_sh_flr_done", 32'(cl_sh_flr_done), 32'h0);
         end
      end
      report_test("flr", err_before);
   endtask

   // ----------------------------------------------------------------------
   // Mid-run reset
   // ----------------------------------------------------------------------

   // k counts cycles from the rst_main_n drop
   task automatic test_midrun_reset();
      ddr_stat_req_t req;
      int unsigned   err_before;
      err_before = err_cnt;
      for (int k = -MID_PRE; k <= BLK_RISE_MID; k++)
      begin
         @(posedge clk);
         rst_main_n <= !(k >= 0 && k < MID_LOW);
         for (int ch = 0; ch < `NUM_DDR_STAT; ch++)
         begin
            drive_rand_req(ch, req);
         end
         @(negedge clk);
         if (k >= SYNC_FALL - 1 && k <= SYNC_RISE)
         begin
            check_val("sync_rst_n", 32'(i_cl_dram_dma.sync_rst_n),
                      32'(k < SYNC_FALL || k == SYNC_RISE));
         end
         // Traffic still on the pipes right before they clear
         if (k == SYNC_FALL)
         begin
            for (int ch = 0; ch < `NUM_DDR_STAT; ch++)
            begin
               check_val($sformatf("sh_ddr_stat_wr_q[%0d] | sh_ddr_stat_rd_q[%0d]", ch, ch),
                         32'(sh_ddr_stat_wr_q[ch] | sh_ddr_stat_rd_q[ch]), 32'h1);
            end
         end
         if (k > SYNC_FALL && k <= SYNC_RISE)
         begin
            check_stat_zero();
         end
         if (k >= BLK_FALL - 1)
         begin
            check_val("block_rst_n", 32'(block_rst_n),
                      32'({NUM_RST_DOMAINS{k < BLK_FALL || k >= BLK_RISE_MID}}));
         end
      end
      @(posedge clk);
      drive_idle_all();
      repeat (LAT + 2) @(posedge clk);
      report_test("midrun_reset", err_before);
   endtask

//--- verif/tb_cl_dram_dma.sv
// Testbench for the DRAM DMA shell with a DDR status responder and directed tests
`include "cl_dram_consts.svh"

module tb_cl_dram_dma
   import cl_rst_pkg::*;
   import cl_ddr_stat_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   // ----------------------------------------------------------------------
   // Test constants
   // ----------------------------------------------------------------------

   localparam int CLK_PERIOD   = 20;
   localparam int RST_CYCLES   = 8;
   localparam int LAT          = `NUM_CFG_STGS_CL_DDR_ATG;
   // rst_main_n to block_rst_n through pipe, sync and block stages
   localparam int BLK_RST_RISE = `RST_PIPE_STGS + `RST_SYNC_STGS + `RST_PIPE_STGS;
   localparam int REQ_BEATS    = 16;
   localparam int RSP_ISSUE    = 24;
   localparam int FLR_HOLD     = 8;
   // Mid-run pulse, offsets counted from the rst_main_n drop
   localparam int MID_PRE      = LAT + 2;
   localparam int MID_LOW      = 4;
   localparam int SYNC_FALL    = `RST_PIPE_STGS + 1;
   localparam int SYNC_RISE    = MID_LOW + `RST_PIPE_STGS + `RST_SYNC_STGS;
   localparam int BLK_FALL     = SYNC_FALL + `RST_PIPE_STGS;
   localparam int BLK_RISE_MID = SYNC_RISE + `RST_PIPE_STGS;
   // Sum of all test lengths
   localparam int TEST_CYCLES  = RST_CYCLES + BLK_RST_RISE + REQ_BEATS + LAT
                                 + (LAT + 2) + RSP_ISSUE + 2 * LAT + 3
                                 + FLR_HOLD + 5 + MID_PRE + BLK_RISE_MID + LAT + 3;
   localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 50;

   // ----------------------------------------------------------------------
   // DUT signals
   // ----------------------------------------------------------------------

   logic                        clk;
   logic                        rst_main_n;
   logic                        sh_cl_flr_assert;
   logic                        cl_sh_flr_done;
   blk_rst_t                    block_rst_n;

   logic                        sh_ddr_stat_wr      [`NUM_DDR_STAT];
   logic                        sh_ddr_stat_rd      [`NUM_DDR_STAT];
   logic [`DDR_STAT_ADDR_W-1:0] sh_ddr_stat_addr    [`NUM_DDR_STAT];
   logic [`DDR_STAT_DATA_W-1:0] sh_ddr_stat_wdata   [`NUM_DDR_STAT];
   logic                        ddr_sh_stat_ack     [`NUM_DDR_STAT];
   logic [`DDR_STAT_INT_W-1:0]  ddr_sh_stat_int     [`NUM_DDR_STAT];
   logic [`DDR_STAT_DATA_W-1:0] ddr_sh_stat_rdata   [`NUM_DDR_STAT];
   logic                        sh_ddr_stat_wr_q    [`NUM_DDR_STAT];
   logic                        sh_ddr_stat_rd_q    [`NUM_DDR_STAT];
   logic [`DDR_STAT_ADDR_W-1:0] sh_ddr_stat_addr_q  [`NUM_DDR_STAT];
   logic [`DDR_STAT_DATA_W-1:0] sh_ddr_stat_wdata_q [`NUM_DDR_STAT];
   logic                        ddr_sh_stat_ack_q   [`NUM_DDR_STAT];
   logic [`DDR_STAT_INT_W-1:0]  ddr_sh_stat_int_q   [`NUM_DDR_STAT];
   logic [`DDR_STAT_DATA_W-1:0] ddr_sh_stat_rdata_q [`NUM_DDR_STAT];

   // Bookkeeping
   int unsigned   cyc = 0;
   int unsigned   err_cnt = 0;
   int unsigned   chk_cnt = 0;
   int unsigned   test_cnt = 0;
   int unsigned   test_pass_cnt = 0;
   integer        seed;
   // Responses in flight on the return pipes, with the cycle each is due
   ddr_stat_rsp_t exp_rsp [`NUM_DDR_STAT][$];
   int unsigned   exp_due [`NUM_DDR_STAT][$];

   // ----------------------------------------------------------------------
   // Clock, cycle count, DUT
   // ----------------------------------------------------------------------

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // Edge number, read at the falling edge
   always @(posedge clk)
   begin
      cyc <= cyc + 1;
   end

   cl_dram_dma i_cl_dram_dma
   (
      .clk_main_a0         (clk),
      .rst_main_n          (rst_main_n),
      .sh_cl_flr_assert    (sh_cl_flr_assert),
      .cl_sh_flr_done      (cl_sh_flr_done),
      .block_rst_n         (block_rst_n),
      .sh_ddr_stat_wr      (sh_ddr_stat_wr),
      .sh_ddr_stat_rd      (sh_ddr_stat_rd),
      .sh_ddr_stat_addr    (sh_ddr_stat_addr),
      .sh_ddr_stat_wdata   (sh_ddr_stat_wdata),
      .ddr_sh_stat_ack     (ddr_sh_stat_ack),
      .ddr_sh_stat_int     (ddr_sh_stat_int),
      .ddr_sh_stat_rdata   (ddr_sh_stat_rdata),
      .sh_ddr_stat_wr_q    (sh_ddr_stat_wr_q),
      .sh_ddr_stat_rd_q    (sh_ddr_stat_rd_q),
      .sh_ddr_stat_addr_q  (sh_ddr_stat_addr_q),
      .sh_ddr_stat_wdata_q (sh_ddr_stat_wdata_q),
      .ddr_sh_stat_ack_q   (ddr_sh_stat_ack_q),
      .ddr_sh_stat_int_q   (ddr_sh_stat_int_q),
      .ddr_sh_stat_rdata_q (ddr_sh_stat_rdata_q)
   );

   // ----------------------------------------------------------------------
   // DDR controller status responder
   // ----------------------------------------------------------------------

   // Answers every strobe seen on the controller side on the next edge
   initial
   begin
      ddr_stat_rsp_t rsp;
      for (int ch = 0; ch < `NUM_DDR_STAT; ch++)
      begin
         ddr_sh_stat_ack_q[ch]   = 1'b0;
         ddr_sh_stat_int_q[ch]   = '0;
         ddr_sh_stat_rdata_q[ch] = '0;
      end
      forever
      begin
         @(posedge clk);
         for (int ch = 0; ch < `NUM_DDR_STAT; ch++)
         begin
            rsp = '0;
            if (sh_ddr_stat_wr_q[ch] === 1'b1 || sh_ddr_stat_rd_q[ch] === 1'b1)
            begin
               rsp.ack   = 1'b1;
               rsp.intr  = sh_ddr_stat_addr_q[ch] ^ 8'(ch);
               // Writes echo inverted data, reads return the address pattern
               rsp.rdata = sh_ddr_stat_wr_q[ch] ? ~sh_ddr_stat_wdata_q[ch]
                                                : {4{sh_ddr_stat_addr_q[ch]}};
               exp_rsp[ch].push_back(rsp);
               // Driven on edge cyc+1, leaves the return pipe LAT edges later
               exp_due[ch].push_back(cyc + 1 + LAT);
            end
            ddr_sh_stat_ack_q[ch]   <= rsp.ack;
            ddr_sh_stat_int_q[ch]   <= rsp.intr;
            ddr_sh_stat_rdata_q[ch] <= rsp.rdata;
         end
      end
   end

   // ----------------------------------------------------------------------
   // Check, report and drive helpers
   // ----------------------------------------------------------------------

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
      chk_cnt++;
      assert (got === want)
      else
      begin
         $display("** Error %s: got 0x%h, expected 0x%h at cycle %0d", name, got, want, cyc);
         err_cnt++;
      end
   endtask

   task automatic check_cond(input logic cond, input string what);
      chk_cnt++;
      assert (cond === 1'b1)
      else
      begin
         $display("Error at cycle %0d: %s", cyc, what);
         err_cnt++;
      end
   endtask

   // Every status output and the FLR done idle
   task automatic check_stat_zero();
      for (int ch = 0; ch < `NUM_DDR_STAT; ch++)
      begin
         check_val($sformatf("sh_ddr_stat_wr_q[%0d]", ch), 32'(sh_ddr_stat_wr_q[ch]), 32'h0);
         check_val($sformatf("sh_ddr_stat_rd_q[%0d]", ch), 32'(sh_ddr_stat_rd_q[ch]), 32'h0);
         check_val($sformatf("sh_ddr_stat_addr_q[%0d]", ch), 32'(sh_ddr_stat_addr_q[ch]), 32'h0);
         check_val($sformatf("sh_ddr_stat_wdata_q[%0d]", ch), sh_ddr_stat_wdata_q[ch], 32'h0);
         check_val($sformatf("ddr_sh_stat_ack[%0d]", ch), 32'(ddr_sh_stat_ack[ch]), 32'h0);
         check_val($sformatf("ddr_sh_stat_int[%0d]", ch), 32'(ddr_sh_stat_int[ch]), 32'h0);
         check_val($sformatf("ddr_sh_stat_rdata[%0d]", ch), ddr_sh_stat_rdata[ch], 32'h0);
      end
      check_val("cl_sh_flr_done", 32'(cl_sh_flr_done), 32'h0);
   endtask

   task automatic report_test(input string name, input int unsigned err_before);
      test_cnt++;
      if (err_cnt == err_before)
      begin
         test_pass_cnt++;
         $display("PASS %s", name);
      end
      else
      begin
         $display("FAIL %s with %0d errors", name, err_cnt - err_before);
      end
   endtask

   // Called on a rising edge
   task automatic drive_idle(input int ch);
      sh_ddr_stat_wr[ch]    <= 1'b0;
      sh_ddr_stat_rd[ch]    <= 1'b0;
      sh_ddr_stat_addr[ch]  <= '0;
      sh_ddr_stat_wdata[ch] <= '0;
   endtask

   task automatic drive_idle_all();
      for (int ch = 0; ch < `NUM_DDR_STAT; ch++)
      begin
         drive_idle(ch);
      end
   endtask

   // Write or read strobe, never both, with fresh address and data
   task automatic drive_rand_req(input int ch, output ddr_stat_req_t req);
      logic [31:0] r;
      r = $random(seed);
      req.wr    = r[0];
      req.rd    = ~r[0];
      req.addr  = r[15:8];
      req.wdata = $random(seed);
      sh_ddr_stat_wr[ch]    <= req.wr;
      sh_ddr_stat_rd[ch]    <= req.rd;
      sh_ddr_stat_addr[ch]  <= req.addr;
      sh_ddr_stat_wdata[ch] <= req.wdata;
   endtask

   `include "tb_cl_dram_dma_tasks.svh"

   // ----------------------------------------------------------------------
   // Test sequence and watchdog
   // ----------------------------------------------------------------------

   initial
   begin
      seed = 32'h030966d6;
      rst_main_n       <= 1'b0;
      sh_cl_flr_assert <= 1'b0;
      drive_idle_all();
      repeat (RST_CYCLES) @(posedge clk);
      test_reset_release();
      test_request_path();
      test_response_path();
      test_flr();
      test_midrun_reset();
      $display("Summary: %0d tests run, %0d passed, %0d errors in %0d checks",
               test_cnt, test_pass_cnt, err_cnt, chk_cnt);
      if (err_cnt == 0)
      begin
         $display("All checks passed");
      end
      else
      begin
         $display("Checks failed");
      end
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
      $display("Checks failed");
      $finish;
   end

endmodule

//--- source/cl_dram_dma.sv
// DRAM DMA shell top with reset control and retimed DDR status ports
`include "cl_dram_consts.svh"

module cl_dram_dma
   import cl_rst_pkg::*;
   import cl_ddr_stat_pkg::*;
(
   // ----------------------------------------------------------------------
   // Clock, reset and FLR
   // ----------------------------------------------------------------------
   input  logic                         clk_main_a0,
   input  logic                         rst_main_n,

   input  logic                         sh_cl_flr_assert,
   output logic                         cl_sh_flr_done,

   output blk_rst_t                     block_rst_n,

   // ----------------------------------------------------------------------
   // Shell side of the status ports
   // ----------------------------------------------------------------------
   input  logic                         sh_ddr_stat_wr    [`NUM_DDR_STAT],
   input  logic                         sh_ddr_stat_rd    [`NUM_DDR_STAT],
   input  logic [`DDR_STAT_ADDR_W-1:0]  sh_ddr_stat_addr  [`NUM_DDR_STAT],
   input  logic [`DDR_STAT_DATA_W-1:0]  sh_ddr_stat_wdata [`NUM_DDR_STAT],

   output logic                         ddr_sh_stat_ack   [`NUM_DDR_STAT],
   output logic [`DDR_STAT_INT_W-1:0]   ddr_sh_stat_int   [`NUM_DDR_STAT],
   output logic [`DDR_STAT_DATA_W-1:0]  ddr_sh_stat_rdata [`NUM_DDR_STAT],

   // ----------------------------------------------------------------------
   // Controller side of the status ports
   // ----------------------------------------------------------------------
   output logic                         sh_ddr_stat_wr_q    [`NUM_DDR_STAT],
   output logic                         sh_ddr_stat_rd_q    [`NUM_DDR_STAT],
   output logic [`DDR_STAT_ADDR_W-1:0]  sh_ddr_stat_addr_q  [`NUM_DDR_STAT],
   output logic [`DDR_STAT_DATA_W-1:0]  sh_ddr_stat_wdata_q [`NUM_DDR_STAT],

   input  logic                         ddr_sh_stat_ack_q   [`NUM_DDR_STAT],
   input  logic [`DDR_STAT_INT_W-1:0]   ddr_sh_stat_int_q   [`NUM_DDR_STAT],
   input  logic [`DDR_STAT_DATA_W-1:0]  ddr_sh_stat_rdata_q [`NUM_DDR_STAT]
);

   // ----------------------------------------------------------------------
   // Clock and reset
   // ----------------------------------------------------------------------

   // Whole design runs on the main shell clock
   logic clk;
   logic sync_rst_n;

   assign clk = clk_main_a0;

   // Reset tree and FLR handshake
   cl_rst_ctrl i_cl_rst_ctrl
   (
      .clk              (clk),
      .rst_main_n       (rst_main_n),
      .sh_cl_flr_assert (sh_cl_flr_assert),
      .sync_rst_n       (sync_rst_n),
      .block_rst_n      (block_rst_n),
      .cl_sh_flr_done   (cl_sh_flr_done)
   );

   // ----------------------------------------------------------------------
   // Status port retiming
   // ----------------------------------------------------------------------

   // One request and one response pipe per channel
   // Closes timing across the die to the DDR controller
   // Fixed latency both ways, no flow control
   for (genvar ch = 0; ch < `NUM_DDR_STAT; ch++)
   begin : g_stat_ch
      ddr_stat_req_t req_in;
      ddr_stat_req_t req_out;
      ddr_stat_rsp_t rsp_in;
      ddr_stat_rsp_t rsp_out;

      // Shell request bundled for the pipe
      assign req_in.wr    = sh_ddr_stat_wr[ch];
      assign req_in.rd    = sh_ddr_stat_rd[ch];
      assign req_in.addr  = sh_ddr_stat_addr[ch];
      assign req_in.wdata = sh_ddr_stat_wdata[ch];

      // Request toward the controller
      lib_pipe
      #(
         .WIDTH  ($bits(ddr_stat_req_t)),
         .STAGES (`NUM_CFG_STGS_CL_DDR_ATG)
      )
      i_pipe_req
      (
         .clk        (clk),
         .pipe_rst_n (sync_rst_n),
         .in_bus     (req_in),
         .out_bus    (req_out)
      );

      // Unbundle at the controller side
      assign sh_ddr_stat_wr_q[ch]    = req_out.wr;
      assign sh_ddr_stat_rd_q[ch]    = req_out.rd;
      assign sh_ddr_stat_addr_q[ch]  = req_out.addr;
      assign sh_ddr_stat_wdata_q[ch] = req_out.wdata;

      // Controller response bundled for the return pipe
      assign rsp_in.ack   = ddr_sh_stat_ack_q[ch];
      assign rsp_in.intr  = ddr_sh_stat_int_q[ch];
      assign rsp_in.rdata = ddr_sh_stat_rdata_q[ch];

      // Response back to the shell
      lib_pipe
      #(
         .WIDTH  ($bits(ddr_stat_rsp_t)),
         .STAGES (`NUM_CFG_STGS_CL_DDR_ATG)
      )
      i_pipe_rsp
      (
         .clk        (clk),
         .pipe_rst_n (sync_rst_n),
         .in_bus     (rsp_in),
         .out_bus    (rsp_out)
      );

      // Unbundle at the shell side
      assign ddr_sh_stat_ack[ch]   = rsp_out.ack;
      assign ddr_sh_stat_int[ch]   = rsp_out.intr;
      assign ddr_sh_stat_rdata[ch] = rsp_out.rdata;
   end

endmodule

//--- source/cl_rst_ctrl.sv
// Reset tree for the DRAM DMA shell with per-block reset pipes and FLR handshake
`include "cl_dram_consts.svh"

module cl_rst_ctrl
   import cl_rst_pkg::*;
(
   input  logic      clk,
   input  logic      rst_main_n,

   // Function-level reset from the shell
   input  logic      sh_cl_flr_assert,

   // Synchronized reset for the shell-side logic
   output logic      sync_rst_n,
   // One delayed copy of sync_rst_n per block
   output blk_rst_t  block_rst_n,

   output logic      cl_sh_flr_done
);

   // ----------------------------------------------------------------------
   // Raw reset pipe
   // ----------------------------------------------------------------------

   // Plain shift register, no reset of its own
   // Relieves fanout and placement of rst_main_n
   logic [`RST_PIPE_STGS-1:0] rst_main_sr;
   logic                      pipe_rst_n;

   always_ff @(posedge clk)
   begin
      rst_main_sr <= {rst_main_sr[`RST_PIPE_STGS-2:0], rst_main_n};
   end

   // rst_main_n of 4 cycles ago
   assign pipe_rst_n = rst_main_sr[`RST_PIPE_STGS-1];

   // ----------------------------------------------------------------------
   // Synchronizer stage
   // ----------------------------------------------------------------------

   // Ones shift in after release
   // Assert one cycle after pipe_rst_n falls
   // Release two cycles after pipe_rst_n rises
   logic [`RST_SYNC_STGS-1:0] sync_sr;

   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         sync_sr <= '0;
      end
      else
      begin
         sync_sr <= {sync_sr[`RST_SYNC_STGS-2:0], 1'b1};
      end
   end

   assign sync_rst_n = sync_sr[`RST_SYNC_STGS-1];

   // ----------------------------------------------------------------------
   // Per-block reset pipes
   // ----------------------------------------------------------------------

   // Each domain gets its own unreset copy of sync_rst_n
   // Lets the tools place each tree next to its block
   for (genvar d = 0; d < NUM_RST_DOMAINS; d++)
   begin : g_blk_rst
      localparam rst_domain_e DOM = rst_domain_e'(d);

      logic [`RST_PIPE_STGS-1:0] dom_sr;

      always_ff @(posedge clk)
      begin
         dom_sr <= {dom_sr[`RST_PIPE_STGS-2:0], sync_rst_n};
      end

      // sync_rst_n of 4 cycles ago, 10 cycles after rst_main_n overall
      assign block_rst_n[DOM] = dom_sr[`RST_PIPE_STGS-1];
   end

   // ----------------------------------------------------------------------
   // FLR response
   // ----------------------------------------------------------------------

   // Assert registered once before use
   logic flr_assert_q;

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q   <= 1'b0;
         cl_sh_flr_done <= 1'b0;
      end
      else
      begin
         flr_assert_q   <= sh_cl_flr_assert;
         // Pulse when done was low
         // Toggles each cycle while the assert is held
         cl_sh_flr_done <= flr_assert_q && !cl_sh_flr_done;
      end
   end

endmodule

//--- source/lib_pipe.sv
// Delay pipe of configurable width and depth with synchronous clear
module lib_pipe
#(
   parameter int unsigned WIDTH  = 8,
   parameter int unsigned STAGES = 4
)
(
   input  logic             clk,
   input  logic             pipe_rst_n,

   input  logic [WIDTH-1:0] in_bus,
   output logic [WIDTH-1:0] out_bus
);

   // ----------------------------------------------------------------------
   // Stage storage
   // ----------------------------------------------------------------------

   // stg[0] is nearest the input
   logic [WIDTH-1:0] stg [STAGES];

   // ----------------------------------------------------------------------
   // Shift
   // ----------------------------------------------------------------------

   // No stall, one word enters and one leaves every cycle
   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         // Whole pipe drains to zero, strobes included
         for (int i = 0; i < STAGES; i++)
         begin
            stg[i] <= '0;
         end
      end
      else
      begin
         stg[0] <= in_bus;
         // Advance the rest
         for (int i = 1; i < STAGES; i++)
         begin
            stg[i] <= stg[i-1];
         end
      end
   end

   // Output is in_bus of STAGES cycles ago
   assign out_bus = stg[STAGES-1];

endmodule

//--- source/cl_ddr_stat_pkg.sv
// DDR status port request and response groupings carried through one pipe each
`include "cl_dram_consts.svh"

package cl_ddr_stat_pkg;

   // ----------------------------------------------------------------------
   // Shell to controller
   // ----------------------------------------------------------------------

   // 1 + 1 + 8 + 32 = 42 bits
   // wr and rd are single-cycle strobes, never both high
   typedef struct packed
   {
      logic                          wr;
      logic                          rd;
      logic [`DDR_STAT_ADDR_W-1:0]   addr;
      logic [`DDR_STAT_DATA_W-1:0]   wdata;
   } ddr_stat_req_t;

   // ----------------------------------------------------------------------
   // Controller to shell
   // ----------------------------------------------------------------------

   // 1 + 8 + 32 = 41 bits
   // ack is a single-cycle pulse
   // intr carries the status int vector; int is a keyword
   typedef struct packed
   {
      logic                          ack;
      logic [`DDR_STAT_INT_W-1:0]    intr;
      logic [`DDR_STAT_DATA_W-1:0]   rdata;
   } ddr_stat_rsp_t;

endpackage

//--- source/cl_rst_pkg.sv
// Reset tree types naming the per-block reset domains of the DRAM DMA shell
package cl_rst_pkg;

   // ----------------------------------------------------------------------
   // Block reset domains
   // ----------------------------------------------------------------------

   // One domain per downstream block
   // Order sets the bit position in blk_rst_t
   typedef enum logic [1:0]
   {
      RST_XBAR,   // AXI crossbar side
      RST_DDR,    // DDR controller and its status port
      RST_SDA     // SDA slave side
   } rst_domain_e;

   // Must track the enum above
   localparam int NUM_RST_DOMAINS = 3;

   // ----------------------------------------------------------------------
   // Block reset vector
   // ----------------------------------------------------------------------

   // One active-low reset bit per domain
   // Index with a rst_domain_e value
   typedef logic [NUM_RST_DOMAINS-1:0] blk_rst_t;

endpackage

//--- source/cl_dram_consts.svh
// DRAM DMA shell constants for status channels, pipe depths and field widths
`ifndef CL_DRAM_CONSTS_SVH
`define CL_DRAM_CONSTS_SVH

// ----------------------------------------------------------------------
// DDR status port
// ----------------------------------------------------------------------

// Status channels served by the DDR controller
`define NUM_DDR_STAT 3

// Retiming stages between shell and DDR controller, per direction
`define NUM_CFG_STGS_CL_DDR_ATG 8

// Status register address width
`define DDR_STAT_ADDR_W 8

// Status register write and read data width
`define DDR_STAT_DATA_W 32

// Interrupt vector returned with each response
`define DDR_STAT_INT_W 8

// ----------------------------------------------------------------------
// Reset tree
// ----------------------------------------------------------------------

// Raw reset pipe, also the depth of each per-block reset pipe
`define RST_PIPE_STGS 4

// Synchronizer stage between pipe_rst_n and sync_rst_n
`define RST_SYNC_STGS 2

`endif
